//--- project.f
+incdir+sim
logic/TrigPkg.sv
logic/PulseShaper.sv
logic/IntervalTimer.sv
logic/HitChannel.sv
logic/ExternalTrig.sv
logic/SelfTrig.sv
logic/TrigGen.sv
sim/TrigGenTb.sv

//--- sim/TrigGenTests.svh
/*
  Directed tests for the trigger generator
  Gating, internal, external, self-OR and self-AND behavior
*/
`ifndef TRIG_GEN_TESTS_SVH
`define TRIG_GEN_TESTS_SVH

// Hit level goes high for two cycles, then the falling edge
task automatic HitFall(input int ch);
  Hit[ch] = 1'b1;
  repeat (2) StepCycle();
  Hit[ch] = 1'b0;
endtask

// Falling edges on two channels, gap cycles apart
task automatic HitPair(input int chA, input int chB, input int gap);
  Hit[chA] = 1'b1;
  Hit[chB] = 1'b1;
  repeat (2) StepCycle();
  Hit[chA] = 1'b0;
  repeat (gap) StepCycle();
  Hit[chB] = 1'b0;
endtask

task automatic PulseExtTrig();
  ExtTrig = 1'b1;
  repeat (3) StepCycle();
  ExtTrig = 1'b0;
endtask

task automatic TestGating();
  TrigMode modes [4];
  int r0;
  modes = '{ModeInternal, ModeExternal, ModeSelfOr, ModeSelfAnd};
  BeginTest();
  CheckEqual("Trig after reset", 0, Trig);
  Start = 1'b0;
  r0 = RiseCount;
  foreach (modes[i])
  begin
    Mode = modes[i];
    for (int n = 0; n < 60; n++)
    begin
      if (n % 3 == 0)
      begin
        ExtTrig = ~ExtTrig;
        Hit     = ~Hit;
      end
      StepCycle();
    end
  end
  CheckEqual("Trig pulses with Start low", 0, RiseCount - r0);
  SettleIdle();
  EndTest("gating and reset");
endtask

task automatic CheckInterval(input TrigMode m, input string label);
  int lo;
  int hi;
  int limit;
  int spacing;
  int prevRise;
  Interval = IntervalWidth'($urandom_range(4, 1));
  lo = int'(Interval) * TickCycles - TickCycles;
  hi = (int'(Interval) + 1) * TickCycles + PulseWidth + 3;
  limit = hi + TickCycles;
  Mode  = m;
  Start = 1'b1;
  WaitForLow(PulseWidth + 2, label);   // Skip a pulse cut by Start
  WaitForRise(RiseCount + 1, limit, label);
  prevRise = RiseTime;
  repeat (3)
  begin
    WaitForRise(RiseCount + 1, limit, label);
    spacing  = RiseTime - prevRise;
    prevRise = RiseTime;
    CheckEqual("Trig width", PulseWidth, LastWidth);
    // Nearest bound stands in as the expected value
    CheckEqual("Trig rise spacing",
               (spacing < lo) ? lo : ((spacing > hi) ? hi : spacing), spacing);
  end
  Start = 1'b0;
endtask

task automatic TestInternal();
  BeginTest();
  CheckInterval(ModeInternal, "internal mode");
  CheckInterval(TrigMode'(4'b0000), "mode 0000");   // Not one-hot
  SettleIdle();
  EndTest("internal mode");
endtask

task automatic TestExternal();
  int r0;
  int t0;
  BeginTest();
  Mode  = ModeExternal;
  Start = 1'b1;
  r0 = RiseCount;
  t0 = StepCount;
  PulseExtTrig();
  WaitForRise(r0 + 1, 10, "external mode");
  CheckEqual("Trig rise delay", 4, RiseTime - t0);
  WaitForLow(PulseWidth + 5, "external mode");
  CheckEqual("Trig width", PulseWidth, LastWidth);

  r0 = RiseCount;
  PulseExtTrig();   // Inside the dead time
  repeat (BusyCycles + 10) StepCycle();
  CheckEqual("Trig pulses in dead time", 0, RiseCount - r0);

  r0 = RiseCount;
  t0 = StepCount;
  PulseExtTrig();
  WaitForRise(r0 + 1, 10, "external mode");
  CheckEqual("Trig rise delay", 4, RiseTime - t0);
  WaitForLow(PulseWidth + 5, "external mode");
  CheckEqual("Trig width", PulseWidth, LastWidth);
  SettleIdle();
  EndTest("external mode");
endtask

task automatic TestSelfOr();
  int r0;
  int gap;
  BeginTest();
  HitEnable = 4'b0101;
  Mode = ModeSelfOr;
  SettleIdle();
  Start = 1'b1;
  r0 = RiseCount;
  HitFall(1);   // Channel 1 is disabled in 0101
  repeat (20) StepCycle();
  CheckEqual("Trig pulses from disabled channel", 0, RiseCount - r0);

  HitFall(0);
  WaitForRise(r0 + 1, 10, "self-OR mode");
  WaitForLow(PulseWidth + 5, "self-OR mode");
  CheckEqual("Trig width", PulseWidth, LastWidth);
  repeat (BusyCycles + 10) StepCycle();
  CheckEqual("Trig pulses from one fall", 1, RiseCount - r0);

  r0 = RiseCount;
  gap = PulseWidth + $urandom_range(10, 1);   // Second fall lands after the pulse ends
  HitPair(0, 2, gap);
  repeat (BusyCycles + PulseWidth + 10) StepCycle();
  CheckEqual("Trig pulses from two falls", 1, RiseCount - r0);
  CheckEqual("Trig width", PulseWidth, LastWidth);
  SettleIdle();
  EndTest("self-OR mode");
endtask

task automatic TestSelfAnd();
  int r0;
  int gap;
  BeginTest();
  HitEnable = 4'b0101;
  Mode = ModeSelfAnd;
  SettleIdle();
  Start = 1'b1;
  r0 = RiseCount;
  HitFall(0);
  repeat (2 * HoldCycles + 10) StepCycle();
  CheckEqual("Trig pulses from channel 0 alone", 0, RiseCount - r0);

  gap = $urandom_range(3, 0);
  HitPair(0, 2, gap);
  WaitForRise(r0 + 1, gap + HoldCycles, "self-AND mode");
  WaitForLow(PulseWidth + 5, "self-AND mode");
  CheckEqual("Trig width", PulseWidth, LastWidth);
  repeat (BusyCycles + 10) StepCycle();
  CheckEqual("Trig pulses from close falls", 1, RiseCount - r0);

  // Windows no longer overlap
  r0 = RiseCount;
  gap = 2 * HoldCycles + 1 + $urandom_range(7, 0);
  HitPair(0, 2, gap);
  repeat (2 * HoldCycles + 10) StepCycle();
  CheckEqual("Trig pulses from distant falls", 0, RiseCount - r0);
  SettleIdle();
  EndTest("self-AND mode");
endtask

`endif

//--- sim/TrigGenTb.sv
/*
  Trigger generator testbench
  Clock, reset, DUT and the shared stepping and check helpers
*/
module TrigGenTb
  import TrigPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PulseWidth   = 5;
  localparam int BusyCycles   = 40;
  localparam int TickCycles   = 20;
  localparam int HoldCycles   = 8;
  localparam int SettleCycles = PulseWidth + BusyCycles + HoldCycles + 10;

  logic                      Clk;
  logic                      Rst_N;
  logic                      Start;
  TrigMode                   Mode;
  logic [IntervalWidth-1:0]  Interval;
  logic                      ExtTrig;
  logic [NumHitChannels-1:0] Hit;
  logic [NumHitChannels-1:0] HitEnable;
  logic                      Trig;

  // Trig as seen once per cycle, plus pulse bookkeeping
  logic TrigNow;
  logic PrevTrig;
  int   StepCount;
  int   RiseCount;
  int   RiseTime;
  int   HighRun;
  int   LastWidth;
  int   ErrCount;
  int   TestErrStart;
  int   TestsPassed;
  int   TestsFailed;

  TrigGen #(
    .PulseWidth (PulseWidth),
    .BusyCycles (BusyCycles),
    .TickCycles (TickCycles),
    .HoldCycles (HoldCycles)
  ) dut0 (
    .Clk       (Clk),
    .Rst_N     (Rst_N),
    .Start     (Start),
    .Mode      (Mode),
    .Interval  (Interval),
    .ExtTrig   (ExtTrig),
    .Hit       (Hit),
    .HitEnable (HitEnable),
    .Trig      (Trig)
  );

  initial
  begin
    Clk = 1'b0;
    forever #50ns Clk = ~Clk;
  end

  // Trig is read before this cycle's drive, so it reflects the last edge
  task automatic StepCycle();
    @(posedge Clk);
    #10ns;
    PrevTrig = TrigNow;
    TrigNow  = Trig;
    StepCount++;
    if (TrigNow && !PrevTrig)
    begin
      RiseCount++;
      RiseTime = StepCount;
      HighRun  = 0;
    end
    if (TrigNow)
      HighRun++;
    else if (PrevTrig)
      LastWidth = HighRun;   // Pulse just ended
  endtask

  task automatic CheckEqual(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
      ErrCount++;
    end
  endtask

  task automatic WaitForRise(input int target, input int limit, input string what);
    int n;
    n = 0;
    while (RiseCount < target && n < limit)
    begin
      StepCycle();
      n++;
    end
    if (RiseCount < target)
    begin
      $display("Timeout: no Trig pulse within %0d cycles in %s", limit, what);
      ErrCount++;
    end
  endtask

  task automatic WaitForLow(input int limit, input string what);
    int n;
    n = 0;
    while (TrigNow !== 1'b0 && n < limit)
    begin
      StepCycle();
      n++;
    end
    if (TrigNow !== 1'b0)
    begin
      $display("Timeout: Trig still high after %0d cycles in %s", limit, what);
      ErrCount++;
    end
  endtask

  // Quiet inputs with Start low until every shaper is idle again
  task automatic SettleIdle();
    Start   = 1'b0;
    ExtTrig = 1'b0;
    Hit     = '0;
    repeat (SettleCycles) StepCycle();
  endtask

  task automatic BeginTest();
    TestErrStart = ErrCount;
  endtask

  task automatic EndTest(input string name);
    if (ErrCount == TestErrStart)
    begin
      $display("%s: ok", name);
      TestsPassed++;
    end
    else
    begin
      $display("%s: %0d errors", name, ErrCount - TestErrStart);
      TestsFailed++;
    end
  endtask

  `include "TrigGenTests.svh"

  initial
  begin
    void'($urandom(32'hdf0228a7));
    Rst_N     = 1'b0;
    Start     = 1'b0;
    Mode      = ModeInternal;
    Interval  = 1;
    ExtTrig   = 1'b0;
    Hit       = '0;
    HitEnable = 4'b1111;
    TrigNow   = 1'b0;
    PrevTrig  = 1'b0;
    StepCount = 0;
    RiseCount = 0;
    RiseTime  = 0;
    HighRun   = 0;
    LastWidth = 0;
    ErrCount  = 0;
    TestsPassed = 0;
    TestsFailed = 0;
    repeat (16) @(posedge Clk);
    #10ns;
    Rst_N = 1'b1;

    TestGating();
    TestInternal();
    TestExternal();
    TestSelfOr();
    TestSelfAnd();

    $display("Tests passed %0d, failed %0d", TestsPassed, TestsFailed);
    if (ErrCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- logic/TrigGen.sv
/*
  Trigger generator top level
  Selects internal, external, self-OR or self-AND trigger by the one-hot mode
  and holds Trig low while Start is low
*/
module TrigGen
  import TrigPkg::*;
#(
  parameter int PulseWidth = 25,
  parameter int BusyCycles = 2500,
  parameter int TickCycles = 50000,
  parameter int HoldCycles = 50
)
(
  input  logic                      Clk,
  input  logic                      Rst_N,
  input  logic                      Start,
  input  TrigMode                   Mode,
  input  logic [IntervalWidth-1:0]  Interval,
  input  logic                      ExtTrig,
  input  logic [NumHitChannels-1:0] Hit,
  input  logic [NumHitChannels-1:0] HitEnable,
  output logic                      Trig
);

  logic IntEnable;
  logic IntTrig;
  logic ExtPulse;
  logic OrPulse;
  logic AndPulse;
  logic SrcTrig;

  always_comb
  begin
    IntEnable = 1'b0;
    case (Mode)
      ModeExternal: SrcTrig = ExtPulse;
      ModeSelfOr:   SrcTrig = OrPulse;
      ModeSelfAnd:  SrcTrig = AndPulse;
      default:      // Internal, also any code that is not one-hot
      begin
        SrcTrig   = IntTrig;
        IntEnable = 1'b1;
      end
    endcase
  end

  assign Trig = Start & SrcTrig;

  IntervalTimer #(
    .TickCycles (TickCycles),
    .PulseWidth (PulseWidth)
  ) IntTimer (
    .Clk      (Clk),
    .Rst_N    (Rst_N),
    .Enable   (IntEnable),
    .Interval (Interval),
    .IntTrig  (IntTrig)
  );

  ExternalTrig #(
    .PulseWidth (PulseWidth),
    .BusyCycles (BusyCycles)
  ) ExtPath (
    .Clk      (Clk),
    .Rst_N    (Rst_N),
    .ExtTrig  (ExtTrig),
    .ExtPulse (ExtPulse)
  );

  SelfTrig #(
    .PulseWidth (PulseWidth),
    .BusyCycles (BusyCycles),
    .HoldCycles (HoldCycles)
  ) SelfPath (
    .Clk       (Clk),
    .Rst_N     (Rst_N),
    .Hit       (Hit),
    .HitEnable (HitEnable),
    .OrPulse   (OrPulse),
    .AndPulse  (AndPulse)
  );

endmodule

//--- logic/SelfTrig.sv
/*
  Self trigger from the ASIC hit signals
  OR pulse on any enabled channel's falling edge, AND pulse when every
  channel is inside its hold window
*/
module SelfTrig
  import TrigPkg::*;
#(
  parameter int PulseWidth = 25,
  parameter int BusyCycles = 2500,
  parameter int HoldCycles = 50
)
(
  input  logic                      Clk,
  input  logic                      Rst_N,
  input  logic [NumHitChannels-1:0] Hit,
  input  logic [NumHitChannels-1:0] HitEnable,
  output logic                      OrPulse,
  output logic                      AndPulse
);

  logic [NumHitChannels-1:0] Fall;
  logic [NumHitChannels-1:0] Held;
  logic AnyFall;
  logic AllHeld;

  for (genvar i = 0; i < NumHitChannels; i++)
  begin : gChan
    HitChannel #(
      .HoldCycles (HoldCycles)
    ) Chan (
      .Clk       (Clk),
      .Rst_N     (Rst_N),
      .Hit       (Hit[i]),
      .HitEnable (HitEnable[i]),
      .Fall      (Fall[i]),
      .Held      (Held[i])
    );
  end

  assign AnyFall = |Fall;
  assign AllHeld = &Held;   // Disabled channels hold high

  PulseShaper #(
    .PulseWidth (PulseWidth),
    .BusyCycles (BusyCycles)
  ) OrShaper (
    .Clk   (Clk),
    .Rst_N (Rst_N),
    .Fire  (AnyFall),
    .Pulse (OrPulse)
  );

  PulseShaper #(
    .PulseWidth (PulseWidth),
    .BusyCycles (BusyCycles)
  ) AndShaper (
    .Clk   (Clk),
    .Rst_N (Rst_N),
    .Fire  (AllHeld),
    .Pulse (AndPulse)
  );

endmodule

//--- logic/ExternalTrig.sv
/*
  External trigger path
  Brings ExtTrig into the clock domain and shapes it into one trigger pulse
*/
module ExternalTrig #(
  parameter int PulseWidth = 25,
  parameter int BusyCycles = 2500
)
(
  input  logic Clk,
  input  logic Rst_N,
  input  logic ExtTrig,
  output logic ExtPulse
);

  logic Sync1;
  logic Sync2;

  // Two-flop synchronizer for the asynchronous input
  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      Sync1 <= 1'b0;
      Sync2 <= 1'b0;
    end
    else
    begin
      Sync1 <= ExtTrig;
      Sync2 <= Sync1;
    end
  end

  PulseShaper #(
    .PulseWidth (PulseWidth),
    .BusyCycles (BusyCycles)
  ) ExtShaper (
    .Clk   (Clk),
    .Rst_N (Rst_N),
    .Fire  (Sync2),   // Level, only sampled when the shaper is idle
    .Pulse (ExtPulse)
  );

endmodule

//--- logic/HitChannel.sv
/*
  One ASIC hit channel
  Synchronizes the hit level, strobes Fall on its falling edge and keeps Held
  high for the AND hold window; a disabled channel is always held
*/
module HitChannel
  import TrigPkg::*;
#(
  parameter int HoldCycles = 50
)
(
  input  logic Clk,
  input  logic Rst_N,
  input  logic Hit,
  input  logic HitEnable,
  output logic Fall,
  output logic Held
);

  localparam int HoldBits = $clog2(HoldCycles + 1);
  localparam logic [HoldBits-1:0] HoldLast = HoldBits'(HoldCycles);

  HoldState State;
  HoldState NextState;
  logic Sync1;
  logic Sync2;
  logic [HoldBits-1:0] HoldCnt;

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      Sync1 <= 1'b0;
      Sync2 <= 1'b0;
      Fall  <= 1'b0;
    end
    else
    begin
      Sync1 <= HitEnable & Hit;   // Cleared while disabled
      Sync2 <= HitEnable & Sync1;
      Fall  <= HitEnable & Sync2 & ~Sync1;
    end
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
      State <= HoldIdle;
    else
      State <= NextState;
  end

  always_comb
  begin
    NextState = State;
    case (State)
      HoldIdle:
        if (!HitEnable)
          NextState = HoldMasked;
        else if (Fall)
          NextState = HoldActive;
      HoldActive:
        if (!HitEnable)
          NextState = HoldMasked;
        else if (!Fall && HoldCnt == HoldLast)
          NextState = HoldIdle;
      HoldMasked:
        if (HitEnable)
          NextState = HoldIdle;
      default:
        NextState = HoldIdle;
    endcase
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      HoldCnt <= '0;
      Held    <= 1'b1;
    end
    else
    begin
      // A new fall restarts the window
      HoldCnt <= (State == HoldActive && !Fall) ? HoldCnt + 1'b1 : '0;
      Held    <= (NextState != HoldIdle);
    end
  end

endmodule

//--- logic/IntervalTimer.sv
/*
  Interval timer for internal mode
  A free-running prescaler makes coarse ticks; after Interval ticks the timer
  drives IntTrig high for PulseWidth cycles and starts counting again
*/
module IntervalTimer
  import TrigPkg::*;
#(
  parameter int TickCycles = 50000,
  parameter int PulseWidth = 25
)
(
  input  logic                     Clk,
  input  logic                     Rst_N,
  input  logic                     Enable,
  input  logic [IntervalWidth-1:0] Interval,
  output logic                     IntTrig
);

  localparam int TickBits  = $clog2(TickCycles + 1);
  localparam int WidthBits = $clog2(PulseWidth + 1);
  localparam logic [TickBits-1:0]  TickLast  = TickBits'(TickCycles - 1);
  localparam logic [WidthBits-1:0] WidthLast = WidthBits'(PulseWidth - 1);

  IntervalState State;
  IntervalState NextState;
  logic [TickBits-1:0]      TickCnt;
  logic                     Tick;
  logic [IntervalWidth-1:0] TickNum;
  logic [WidthBits-1:0]     HighCnt;

  // Prescaler runs regardless of mode, so the first tick phase is arbitrary
  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      TickCnt <= '0;
      Tick    <= 1'b0;
    end
    else if (TickCnt == TickLast)
    begin
      TickCnt <= '0;
      Tick    <= 1'b1;
    end
    else
    begin
      TickCnt <= TickCnt + 1'b1;
      Tick    <= 1'b0;
    end
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
      State <= IntervalIdle;
    else
      State <= NextState;
  end

  always_comb
  begin
    NextState = State;
    if (!Enable)
      NextState = IntervalIdle;   // Mode changed away
    else
    begin
      case (State)
        IntervalIdle:
          NextState = IntervalCount;
        IntervalCount:
          if (TickNum == Interval)
            NextState = IntervalHigh;
        IntervalHigh:
          if (HighCnt == WidthLast)
            NextState = IntervalCount;
        default:
          NextState = IntervalIdle;
      endcase
    end
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      TickNum <= '0;
      HighCnt <= '0;
      IntTrig <= 1'b0;
    end
    else
    begin
      if (State == IntervalCount && Tick)
        TickNum <= TickNum + 1'b1;
      else if (State != IntervalCount)
        TickNum <= '0;
      HighCnt <= (State == IntervalHigh) ? HighCnt + 1'b1 : '0;
      IntTrig <= (State == IntervalHigh);
    end
  end

endmodule

//--- logic/PulseShaper.sv
/*
  Pulse shaper
  Turns an accepted Fire into one fixed-width pulse followed by a dead time
*/
module PulseShaper
  import TrigPkg::*;
#(
  parameter int PulseWidth = 25,
  parameter int BusyCycles = 2500
)
(
  input  logic Clk,
  input  logic Rst_N,
  input  logic Fire,
  output logic Pulse
);

  localparam int WidthBits = $clog2(PulseWidth + 1);
  localparam int BusyBits  = $clog2(BusyCycles + 1);
  localparam logic [WidthBits-1:0] WidthLast = WidthBits'(PulseWidth - 1);
  localparam logic [BusyBits-1:0]  BusyLast  = BusyBits'(BusyCycles - 1);

  PulseState State;
  PulseState NextState;
  logic [WidthBits-1:0] WidthCnt;
  logic [BusyBits-1:0]  BusyCnt;

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
      State <= PulseIdle;
    else
      State <= NextState;
  end

  always_comb
  begin
    NextState = State;
    case (State)
      PulseIdle:
        if (Fire)   // Fire only matters here, events in Send or Busy are lost
          NextState = PulseSend;
      PulseSend:
        if (WidthCnt == WidthLast)
          NextState = PulseBusy;
      PulseBusy:
        if (BusyCnt == BusyLast)
          NextState = PulseIdle;
      default:
        NextState = PulseIdle;
    endcase
  end

  always_ff @(posedge Clk or negedge Rst_N)
  begin
    if (!Rst_N)
    begin
      WidthCnt <= '0;
      BusyCnt  <= '0;
      Pulse    <= 1'b0;
    end
    else
    begin
      WidthCnt <= (State == PulseSend) ? WidthCnt + 1'b1 : '0;
      BusyCnt  <= (State == PulseBusy) ? BusyCnt + 1'b1 : '0;
      Pulse    <= (State == PulseSend);   // One cycle behind the state
    end
  end

endmodule

//--- logic/TrigPkg.sv
/*
  Trigger generator shared definitions
  Mode codes, FSM state encodings and the fixed sizes used across the design
*/
package TrigPkg;

  // One-hot trigger mode code
  typedef enum logic [3:0] {
    ModeInternal = 4'b0001,
    ModeExternal = 4'b0010,
    ModeSelfOr   = 4'b0100,
    ModeSelfAnd  = 4'b1000
  } TrigMode;

  // Pulse and dead time engine
  typedef enum logic [1:0] {
    PulseIdle = 2'd0,
    PulseSend = 2'd1,
    PulseBusy = 2'd2
  } PulseState;

  // Periodic trigger timer
  typedef enum logic [1:0] {
    IntervalIdle  = 2'd0,
    IntervalCount = 2'd1,
    IntervalHigh  = 2'd2
  } IntervalState;

  // AND hold window of one hit channel
  typedef enum logic [1:0] {
    HoldIdle   = 2'd0,
    HoldActive = 2'd1,
    HoldMasked = 2'd2   // Channel disabled, counts as hit
  } HoldState;

  localparam int NumHitChannels = 4;   // ASIC hit inputs
  localparam int IntervalWidth  = 8;

endpackage
